// File: verilog/csr_pkg.sv
package csr_pkg;

    // widths
    localparam int csr_data_w = 32;
    localparam int csr_addr_w = 14;
    localparam int hw_int_w   = 8;
    localparam int int_w      = 13;
    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;
    localparam int plv_w      = 2;

    //////////////////////////////
    // csr addresses
    //////////////////////////////
    localparam logic [csr_addr_w-1:0] csr_crmd   = 14'h000;
    localparam logic [csr_addr_w-1:0] csr_prmd   = 14'h001;
    localparam logic [csr_addr_w-1:0] csr_ecfg   = 14'h004;
    localparam logic [csr_addr_w-1:0] csr_estat  = 14'h005;
    localparam logic [csr_addr_w-1:0] csr_era    = 14'h006;
    localparam logic [csr_addr_w-1:0] csr_eentry = 14'h00c;
    localparam logic [csr_addr_w-1:0] csr_save0  = 14'h030;
    localparam logic [csr_addr_w-1:0] csr_save1  = 14'h031;
    localparam logic [csr_addr_w-1:0] csr_save2  = 14'h032;
    localparam logic [csr_addr_w-1:0] csr_save3  = 14'h033;
    localparam logic [csr_addr_w-1:0] csr_tcfg   = 14'h041;
    localparam logic [csr_addr_w-1:0] csr_tval   = 14'h042;
    localparam logic [csr_addr_w-1:0] csr_ticlr  = 14'h044;

    //////////////////////////////
    // field positions
    //////////////////////////////
    // prmd pplv and pie sit at the same bits as crmd plv and ie
    localparam int crmd_plv_lsb       = 0;
    localparam int crmd_ie_bit        = 2;
    localparam int estat_is_lsb       = 0;
    localparam int estat_ecode_lsb    = 16;
    localparam int estat_esubcode_lsb = 22;
    localparam int eentry_lsb         = 6;
    localparam int tcfg_en_bit        = 0;
    localparam int tcfg_periodic_bit  = 1;
    localparam int tcfg_initval_lsb   = 2;
    localparam int ticlr_clr_bit      = 0;

    // software writable bits per register
    localparam logic [csr_data_w-1:0] crmd_wmask   = 32'h0000_0007;
    localparam logic [csr_data_w-1:0] prmd_wmask   = 32'h0000_0007;
    localparam logic [csr_data_w-1:0] ecfg_wmask   = 32'h0000_1bff;
    localparam logic [csr_data_w-1:0] estat_wmask  = 32'h0000_0003;
    localparam logic [csr_data_w-1:0] eentry_wmask = 32'hffff_ffc0;

    // bus stage to register stages
    typedef struct packed {
        logic                  valid;
        logic [csr_addr_w-1:0] addr;
        logic [csr_data_w-1:0] mask;
        logic [csr_data_w-1:0] data;
    } csr_wr_t;

    // exception events from the core
    typedef struct packed {
        logic                  store_state;
        logic                  restore_state;
        logic                  ecode_we;
        logic [ecode_w:0]      ecode_in;
        logic                  era_we;
        logic [csr_data_w-1:0] era_in;
    } csr_exc_t;

    typedef struct packed {
        logic [csr_data_w-1:0] crmd;
        logic [csr_data_w-1:0] prmd;
        logic [csr_data_w-1:0] ecfg;
        logic [csr_data_w-1:0] estat;
        logic [csr_data_w-1:0] era;
        logic [csr_data_w-1:0] eentry;
        logic [csr_data_w-1:0] save0;
        logic [csr_data_w-1:0] save1;
        logic [csr_data_w-1:0] save2;
        logic [csr_data_w-1:0] save3;
        logic [csr_data_w-1:0] tcfg;
        logic [csr_data_w-1:0] tval;
        logic [csr_data_w-1:0] ticlr;
    } csr_view_t;

    function automatic logic wr_hit(input csr_wr_t w, input logic [csr_addr_w-1:0] a);
        return w.valid && (w.addr == a);
    endfunction

    // bitwise merge under a write mask
    function automatic logic [csr_data_w-1:0] masked_merge(
        input logic [csr_data_w-1:0] old_word,
        input logic [csr_data_w-1:0] new_word,
        input logic [csr_data_w-1:0] mask
    );
        return (old_word & ~mask) | (new_word & mask);
    endfunction

endpackage

// File: verilog/csr_wb_port.sv
`timescale 1ns/1ps

module csr_wb_port (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [csr_pkg::csr_addr_w-1:0]    adr,
    input  logic [csr_pkg::csr_data_w-1:0]    dat_w,
    input  logic [csr_pkg::csr_data_w-1:0]    wmask,
    input  csr_pkg::csr_view_t                view,
    output logic                              ack,
    output logic [csr_pkg::csr_data_w-1:0]    dat_r,
    output csr_pkg::csr_wr_t                  wr
);
    import csr_pkg::*;

    logic                  req;
    logic                  wr_valid;
    logic [csr_addr_w-1:0] wr_addr;
    logic [csr_data_w-1:0] wr_mask;
    logic [csr_data_w-1:0] wr_data;
    logic [csr_data_w-1:0] rd_word;

    // one sample per transfer, ack blocks the repeat
    assign req = cyc && stb && !ack;

    //////////////////////////////
    // read mux
    //////////////////////////////
    always_comb begin
        case (adr)
            csr_crmd:   rd_word = view.crmd;
            csr_prmd:   rd_word = view.prmd;
            csr_ecfg:   rd_word = view.ecfg;
            csr_estat:  rd_word = view.estat;
            csr_era:    rd_word = view.era;
            csr_eentry: rd_word = view.eentry;
            csr_save0:  rd_word = view.save0;
            csr_save1:  rd_word = view.save1;
            csr_save2:  rd_word = view.save2;
            csr_save3:  rd_word = view.save3;
            csr_tcfg:   rd_word = view.tcfg;
            csr_tval:   rd_word = view.tval;
            csr_ticlr:  rd_word = view.ticlr;
            default:    rd_word = '0;
        endcase
    end

    //////////////////////////////
    // request capture
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ack      <= 1'b0;
            wr_valid <= 1'b0;
        end else begin
            ack      <= req;
            wr_valid <= req && we;
        end
        // payload only moves on a new request
        if (req) begin
            dat_r   <= rd_word;
            wr_addr <= adr;
            wr_mask <= wmask;
            wr_data <= dat_w;
        end
    end

    assign wr = '{valid: wr_valid, addr: wr_addr, mask: wr_mask, data: wr_data};

    // no ack without a strobe in the cycle before
    a_ack_after_stb: assert property (
        @(posedge clk) disable iff (!rstn)
        ack |-> $past(stb)
    );

endmodule

// File: verilog/csr_exc_regs.sv
`timescale 1ns/1ps

module csr_exc_regs (
    input  logic                            clk,
    input  logic                            rstn,
    input  csr_pkg::csr_wr_t                wr,
    input  csr_pkg::csr_exc_t               exc,
    input  logic [csr_pkg::hw_int_w-1:0]    hw_int,
    input  logic                            timer_irq,
    output csr_pkg::csr_view_t              view_exc,
    output logic [csr_pkg::plv_w-1:0]       plv,
    output logic [csr_pkg::ecode_w-1:0]     ecode,
    output logic [csr_pkg::csr_data_w-1:0]  era,
    output logic [csr_pkg::csr_data_w-1:0]  eentry,
    output logic                            irq_pending,
    output logic                            idle_wake
);
    import csr_pkg::*;

    logic [plv_w-1:0]                  crmd_plv;
    logic                              crmd_ie;
    logic [plv_w-1:0]                  prmd_pplv;
    logic                              prmd_pie;
    logic [int_w-1:0]                  ecfg_lie;
    logic [1:0]                        estat_sw;
    logic [ecode_w-1:0]                estat_ecode;
    logic [esubcode_w-1:0]             estat_esubcode;
    logic [csr_data_w-1:0]             era_q;
    logic [csr_data_w-1:eentry_lsb]    eentry_va;
    logic [3:0][csr_data_w-1:0]        save_q;

    logic [int_w-1:0]      estat_is;
    logic [csr_data_w-1:0] crmd_word;
    logic [csr_data_w-1:0] prmd_word;
    logic [csr_data_w-1:0] ecfg_word;
    logic [csr_data_w-1:0] estat_word;
    logic [csr_data_w-1:0] eentry_word;
    logic [csr_data_w-1:0] crmd_sw;
    logic [csr_data_w-1:0] prmd_sw;
    logic [csr_data_w-1:0] ecfg_sw;
    logic [csr_data_w-1:0] estat_sw_word;
    logic [csr_data_w-1:0] eentry_sw;

    // ipi, ti, reserved, hwi, swi
    assign estat_is = {1'b0, timer_irq, 1'b0, hw_int, estat_sw};

    //////////////////////////////
    // register words
    //////////////////////////////
    always_comb begin
        crmd_word = '0;
        crmd_word[crmd_plv_lsb +: plv_w] = crmd_plv;
        crmd_word[crmd_ie_bit] = crmd_ie;
        prmd_word = '0;
        prmd_word[crmd_plv_lsb +: plv_w] = prmd_pplv;
        prmd_word[crmd_ie_bit] = prmd_pie;
        ecfg_word = '0;
        ecfg_word[int_w-1:0] = ecfg_lie;
        estat_word = '0;
        estat_word[estat_is_lsb +: int_w] = estat_is;
        estat_word[estat_ecode_lsb +: ecode_w] = estat_ecode;
        estat_word[estat_esubcode_lsb +: esubcode_w] = estat_esubcode;
        eentry_word = '0;
        eentry_word[csr_data_w-1:eentry_lsb] = eentry_va;
    end

    // software view after a masked write, writable bits only
    assign crmd_sw       = masked_merge(crmd_word, wr.data, wr.mask & crmd_wmask);
    assign prmd_sw       = masked_merge(prmd_word, wr.data, wr.mask & prmd_wmask);
    assign ecfg_sw       = masked_merge(ecfg_word, wr.data, wr.mask & ecfg_wmask);
    assign estat_sw_word = masked_merge(estat_word, wr.data, wr.mask & estat_wmask);
    assign eentry_sw     = masked_merge(eentry_word, wr.data, wr.mask & eentry_wmask);

    //////////////////////////////
    // state registers
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else begin
            // restore beats store, both beat software
            if (exc.restore_state) begin
                crmd_plv <= prmd_pplv;
                crmd_ie  <= prmd_pie;
            end else if (exc.store_state) begin
                crmd_plv <= '0;
                crmd_ie  <= 1'b0;
            end else if (wr_hit(wr, csr_crmd)) begin
                crmd_plv <= crmd_sw[crmd_plv_lsb +: plv_w];
                crmd_ie  <= crmd_sw[crmd_ie_bit];
            end
            if (exc.store_state && !exc.restore_state) begin
                prmd_pplv <= crmd_plv;
                prmd_pie  <= crmd_ie;
            end else if (wr_hit(wr, csr_prmd) && !exc.restore_state) begin
                prmd_pplv <= prmd_sw[crmd_plv_lsb +: plv_w];
                prmd_pie  <= prmd_sw[crmd_ie_bit];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ecfg_lie       <= '0;
            estat_sw       <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era_q          <= '0;
        end else begin
            if (wr_hit(wr, csr_ecfg)) begin
                ecfg_lie <= ecfg_sw[int_w-1:0];
            end
            if (exc.ecode_we) begin
                estat_ecode <= exc.ecode_in[ecode_w-1:0];
                // subcode only for a nonzero primary code
                estat_esubcode <= (|exc.ecode_in[ecode_w-1:0]) ?
                                  esubcode_w'(exc.ecode_in[ecode_w]) : '0;
            end else if (wr_hit(wr, csr_estat)) begin
                estat_sw <= estat_sw_word[1:0];
            end
            if (exc.era_we) begin
                era_q <= exc.era_in;
            end else if (wr_hit(wr, csr_era)) begin
                era_q <= masked_merge(era_q, wr.data, wr.mask);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            eentry_va <= '0;
            save_q    <= '0;
        end else begin
            if (wr_hit(wr, csr_eentry)) begin
                eentry_va <= eentry_sw[csr_data_w-1:eentry_lsb];
            end
            for (int i = 0; i < 4; i++) begin
                if (wr_hit(wr, csr_save0 + csr_addr_w'(i))) begin
                    save_q[i] <= masked_merge(save_q[i], wr.data, wr.mask);
                end
            end
        end
    end

    //////////////////////////////
    // outputs
    //////////////////////////////
    always_comb begin
        view_exc        = '0;
        view_exc.crmd   = crmd_word;
        view_exc.prmd   = prmd_word;
        view_exc.ecfg   = ecfg_word;
        view_exc.estat  = estat_word;
        view_exc.era    = era_q;
        view_exc.eentry = eentry_word;
        view_exc.save0  = save_q[0];
        view_exc.save1  = save_q[1];
        view_exc.save2  = save_q[2];
        view_exc.save3  = save_q[3];
    end

    assign plv         = crmd_plv;
    assign ecode       = estat_ecode;
    assign era         = era_q;
    assign eentry      = eentry_word;
    assign irq_pending = crmd_ie & (|(ecfg_lie & estat_is));
    assign idle_wake   = |estat_is;

    // exception entry and return are exclusive
    a_store_restore_excl: assert property (
        @(posedge clk) disable iff (!rstn)
        !(exc.store_state && exc.restore_state)
    );

endmodule

// File: verilog/csr_timer.sv
`timescale 1ns/1ps

module csr_timer (
    input  logic                            clk,
    input  logic                            rstn,
    input  csr_pkg::csr_wr_t                wr,
    output logic [csr_pkg::csr_data_w-1:0]  tcfg,
    output logic [csr_pkg::csr_data_w-1:0]  tval,
    output logic [csr_pkg::csr_data_w-1:0]  ticlr,
    output logic                            timer_irq
);
    import csr_pkg::*;

    logic [csr_data_w-1:0] tcfg_q;
    logic [csr_data_w-1:0] tval_q;
    logic                  reload;
    logic                  time_out;
    logic                  irq_clr;
    logic                  tcfg_en;
    logic                  tcfg_periodic;

    assign tcfg_en       = tcfg_q[tcfg_en_bit];
    assign tcfg_periodic = tcfg_q[tcfg_periodic_bit];
    assign irq_clr       = wr_hit(wr, csr_ticlr) && wr.mask[ticlr_clr_bit]
                           && wr.data[ticlr_clr_bit];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tcfg_q <= '0;
            reload <= 1'b0;
        end else begin
            if (wr_hit(wr, csr_tcfg)) begin
                tcfg_q <= masked_merge(tcfg_q, wr.data, wr.mask);
            end
            // any tcfg write restarts the count
            reload <= wr_hit(wr, csr_tcfg) && (|wr.mask);
        end
    end

    //////////////////////////////
    // down counter
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            tval_q   <= '0;
            time_out <= 1'b0;
        end else if (reload || tval_q == '0) begin
            time_out <= 1'b0;
            // low bits 01 so an initval of zero still fires
            if (reload || (tcfg_periodic && tcfg_en)) begin
                tval_q <= {tcfg_q[csr_data_w-1:tcfg_initval_lsb], 2'b01};
            end
        end else if (tcfg_en) begin
            tval_q   <= tval_q - 1'b1;
            time_out <= (tval_q == csr_data_w'(1));
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            timer_irq <= 1'b0;
        end else if (irq_clr) begin
            timer_irq <= 1'b0;
        end else if (time_out) begin
            timer_irq <= 1'b1;
        end
    end

    assign tcfg  = tcfg_q;
    assign tval  = tval_q;
    assign ticlr = '0;

endmodule

// File: verilog/csr_top.sv
`timescale 1ns/1ps

module csr_top (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            cyc,
    input  logic                            stb,
    input  logic                            we,
    input  logic [csr_pkg::csr_addr_w-1:0]  adr,
    input  logic [csr_pkg::csr_data_w-1:0]  dat_w,
    input  logic [csr_pkg::csr_data_w-1:0]  wmask,
    input  csr_pkg::csr_exc_t               exc,
    input  logic [csr_pkg::hw_int_w-1:0]    hw_int,
    output logic                            ack,
    output logic [csr_pkg::csr_data_w-1:0]  dat_r,
    output logic [csr_pkg::plv_w-1:0]       plv,
    output logic [csr_pkg::ecode_w-1:0]     ecode,
    output logic [csr_pkg::csr_data_w-1:0]  era,
    output logic [csr_pkg::csr_data_w-1:0]  eentry,
    output logic                            irq_pending,
    output logic                            idle_wake
);
    import csr_pkg::*;

    csr_wr_t               wr;
    csr_view_t             view;
    csr_view_t             view_exc;
    logic [csr_data_w-1:0] tcfg;
    logic [csr_data_w-1:0] tval;
    logic [csr_data_w-1:0] ticlr;
    logic                  timer_irq;

    // timer words replace the empty slots of the bank view
    assign view = '{
        crmd:   view_exc.crmd,
        prmd:   view_exc.prmd,
        ecfg:   view_exc.ecfg,
        estat:  view_exc.estat,
        era:    view_exc.era,
        eentry: view_exc.eentry,
        save0:  view_exc.save0,
        save1:  view_exc.save1,
        save2:  view_exc.save2,
        save3:  view_exc.save3,
        tcfg:   tcfg,
        tval:   tval,
        ticlr:  ticlr
    };

    csr_wb_port u_wb_port (
        .clk   (clk),
        .rstn  (rstn),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .wmask (wmask),
        .view  (view),
        .ack   (ack),
        .dat_r (dat_r),
        .wr    (wr)
    );

    csr_exc_regs u_exc_regs (
        .clk         (clk),
        .rstn        (rstn),
        .wr          (wr),
        .exc         (exc),
        .hw_int      (hw_int),
        .timer_irq   (timer_irq),
        .view_exc    (view_exc),
        .plv         (plv),
        .ecode       (ecode),
        .era         (era),
        .eentry      (eentry),
        .irq_pending (irq_pending),
        .idle_wake   (idle_wake)
    );

    csr_timer u_timer (
        .clk       (clk),
        .rstn      (rstn),
        .wr        (wr),
        .tcfg      (tcfg),
        .tval      (tval),
        .ticlr     (ticlr),
        .timer_irq (timer_irq)
    );

endmodule

// File: testbench/tb_csr_checks.svh
`ifndef TB_CSR_CHECKS_SVH
`define TB_CSR_CHECKS_SVH

// 32-bit xorshift step
function automatic logic [csr_data_w-1:0] xorshift32(input logic [csr_data_w-1:0] s);
    logic [csr_data_w-1:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// each mask bit picks the new bit, otherwise the old one stays
function automatic logic [csr_data_w-1:0] merge_under_mask(
    input logic [csr_data_w-1:0] old_word,
    input logic [csr_data_w-1:0] new_word,
    input logic [csr_data_w-1:0] mask
);
    logic [csr_data_w-1:0] res;
    for (int i = 0; i < csr_data_w; i++) begin
        res[i] = mask[i] ? new_word[i] : old_word[i];
    end
    return res;
endfunction

// eentry keeps only the vector address above bit 6
function automatic logic [csr_data_w-1:0] readable_bits(input logic [csr_addr_w-1:0] a);
    return (a == csr_eentry) ? 32'hffff_ffc0 : {csr_data_w{1'b1}};
endfunction

task automatic note_failure(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    n_errors++;
    test_errors++;
endtask

task automatic check_word(
    input string                 name,
    input logic [csr_data_w-1:0] got,
    input logic [csr_data_w-1:0] exp
);
    n_checks++;
    if (got !== exp) begin
        $display("FAILED t=%0t %s got=%h expected=%h", $time, name, got, exp);
        n_errors++;
        test_errors++;
    end
endtask

task automatic check_plv(input string name, input logic [plv_w-1:0] got,
                         input logic [plv_w-1:0] exp);
    n_checks++;
    if (got !== exp) begin
        $display("FAILED t=%0t %s got=%0d expected=%0d", $time, name, got, exp);
        n_errors++;
        test_errors++;
    end
endtask

task automatic check_ecode(input string name, input logic [ecode_w-1:0] got,
                           input logic [ecode_w-1:0] exp);
    n_checks++;
    if (got !== exp) begin
        $display("FAILED t=%0t %s got=%h expected=%h", $time, name, got, exp);
        n_errors++;
        test_errors++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
        $display("FAILED t=%0t %s got=%b expected=%b", $time, name, got, exp);
        n_errors++;
        test_errors++;
    end
endtask

`endif

// File: testbench/tb_csr.sv
`timescale 1ns/1ps

module tb_csr;
    import csr_pkg::*;

    // one line of the stimulus file
    typedef struct packed {
        logic [7:0]            op;
        logic [7:0]            test;
        logic [csr_addr_w-1:0] addr;
        logic [csr_data_w-1:0] mask;
        logic [csr_data_w-1:0] data;
        logic [csr_data_w-1:0] expected;
    } stim_rec_t;

    localparam int clk_period = 40;
    localparam int ack_limit  = 16;

    logic                  clk = 1'b0;
    logic                  rstn;
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [csr_addr_w-1:0] adr;
    logic [csr_data_w-1:0] dat_w;
    logic [csr_data_w-1:0] wmask;
    csr_exc_t              exc;
    logic [hw_int_w-1:0]   hw_int;
    logic                  ack;
    logic [csr_data_w-1:0] dat_r;
    logic [plv_w-1:0]      plv;
    logic [ecode_w-1:0]    ecode;
    logic [csr_data_w-1:0] era;
    logic [csr_data_w-1:0] eentry;
    logic                  irq_pending;
    logic                  idle_wake;

    stim_rec_t             recs[$];
    logic [csr_data_w-1:0] model [logic [csr_addr_w-1:0]];
    logic [csr_data_w-1:0] rng;
    logic                  loaded = 1'b0;
    longint                watchdog_ns;
    int                    cur_test;
    int                    n_tests;
    int                    n_checks;
    int                    n_errors;
    int                    test_errors;

    `include "tb_csr_checks.svh"

    always #(clk_period / 2) clk = ~clk;

    csr_top DUT (
        .clk         (clk),
        .rstn        (rstn),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_w       (dat_w),
        .wmask       (wmask),
        .exc         (exc),
        .hw_int      (hw_int),
        .ack         (ack),
        .dat_r       (dat_r),
        .plv         (plv),
        .ecode       (ecode),
        .era         (era),
        .eentry      (eentry),
        .irq_pending (irq_pending),
        .idle_wake   (idle_wake)
    );

    function automatic logic [csr_data_w-1:0] model_read(input logic [csr_addr_w-1:0] a);
        return model.exists(a) ? model[a] : '0;
    endfunction

    task automatic model_write(input logic [csr_addr_w-1:0] a, input logic [csr_data_w-1:0] m,
                               input logic [csr_data_w-1:0] d);
        model[a] = merge_under_mask(model_read(a), d, m);
    endtask

    //////////////////////////////
    // stimulus file
    //////////////////////////////
    task automatic load_stimulus();
        int                    fd;
        int                    code;
        int                    t;
        logic [63:0]           tok;
        logic [8*256-1:0]      line;
        logic [csr_data_w-1:0] a;
        logic [csr_data_w-1:0] m;
        logic [csr_data_w-1:0] d;
        logic [csr_data_w-1:0] e;
        stim_rec_t             rec;
        fd = $fopen("testbench/csr_stim.txt", "r");
        if (fd == 0) begin
            note_failure("cannot open testbench/csr_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tok);
                if (code == 1) begin
                    if (tok[7:0] == "#") begin
                        code = $fgets(line, fd);
                    end else begin
                        code = $fscanf(fd, "%d %h %h %h %h", t, a, m, d, e);
                        if (code == 5) begin
                            rec.op       = tok[7:0];
                            rec.test     = t[7:0];
                            rec.addr     = a[csr_addr_w-1:0];
                            rec.mask     = m;
                            rec.data     = d;
                            rec.expected = e;
                            recs.push_back(rec);
                        end else begin
                            note_failure("malformed record in stimulus file");
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////
    // bus and event drivers
    //////////////////////////////
    // side is applied in the ack cycle, so it meets the write at the same edge
    task automatic bus_cycle(
        input  logic                  wr_en,
        input  logic [csr_addr_w-1:0] a,
        input  logic [csr_data_w-1:0] m,
        input  logic [csr_data_w-1:0] d,
        input  csr_exc_t              side,
        output logic [csr_data_w-1:0] rdata
    );
        int n;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr_en;
        adr   = a;
        dat_w = d;
        wmask = m;
        n     = 0;
        @(posedge clk);
        #2;
        while (!ack && n < ack_limit) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!ack) begin
            note_failure($sformatf("no ack from the DUT for address %h", a));
        end
        rdata = dat_r;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        exc   = side;
        @(posedge clk);
        #2;
        exc = '0;
    endtask

    task automatic wait_timer_irq(input logic [csr_data_w-1:0] initval);
        int limit;
        int n;
        limit = 4 * int'(initval) + 10;
        n     = 0;
        @(negedge clk);
        while (!irq_pending && n < limit) begin
            @(negedge clk);
            n++;
        end
        n_checks++;
        if (!irq_pending) begin
            note_failure($sformatf("timer interrupt not raised within %0d cycles", limit));
        end
        @(posedge clk);
        #2;
    endtask

    task automatic close_test();
        if (cur_test != 0) begin
            $display("test %0d: %s (%0d errors)", cur_test,
                     (test_errors == 0) ? "pass" : "fail", test_errors);
            n_tests++;
        end
        test_errors = 0;
    endtask

    task automatic run_record(input stim_rec_t r);
        logic [csr_data_w-1:0] rdata;
        logic [csr_data_w-1:0] rmask;
        logic [csr_data_w-1:0] rdat;
        logic [csr_data_w-1:0] rexp;
        csr_exc_t              side;
        side = '0;
        if (int'(r.test) != cur_test) begin
            close_test();
            cur_test = int'(r.test);
        end
        case (r.op)
            "w": begin
                bus_cycle(1'b1, r.addr, r.mask, r.data, side, rdata);
                model_write(r.addr, r.mask, r.data);
            end
            "x": begin
                rng   = xorshift32(rng);
                rmask = rng;
                rng   = xorshift32(rng);
                rdat  = rng;
                bus_cycle(1'b1, r.addr, rmask, rdat, side, rdata);
                model_write(r.addr, rmask, rdat);
            end
            "m": begin
                bus_cycle(1'b0, r.addr, '0, '0, side, rdata);
                rexp = model_read(r.addr) & readable_bits(r.addr);
                check_word($sformatf("dat_r@%h", r.addr), rdata, rexp);
                // the vector output must agree with the register
                if (r.addr == csr_eentry) begin
                    check_word("eentry", eentry, rexp);
                end
            end
            "r": begin
                bus_cycle(1'b0, r.addr, '0, '0, side, rdata);
                check_word($sformatf("dat_r@%h", r.addr), rdata & r.mask, r.expected);
                if (r.addr == csr_estat && (&r.mask[estat_ecode_lsb +: ecode_w])) begin
                    check_ecode("ecode", ecode, r.expected[estat_ecode_lsb +: ecode_w]);
                end
            end
            "k": begin
                // hardware capture against a software write
                if (r.addr == csr_era) begin
                    side.era_we = 1'b1;
                    side.era_in = r.expected;
                    model[csr_era] = r.expected;
                end else begin
                    side.ecode_we = 1'b1;
                    side.ecode_in = r.expected[ecode_w:0];
                end
                bus_cycle(1'b1, r.addr, r.mask, r.data, side, rdata);
            end
            "e": begin
                exc.store_state   = r.addr[0];
                exc.restore_state = r.addr[1];
                exc.ecode_we      = r.addr[2];
                exc.era_we        = r.addr[3];
                exc.ecode_in      = r.mask[ecode_w:0];
                exc.era_in        = r.data;
                if (r.addr[3]) begin
                    model[csr_era] = r.data;
                end
                @(posedge clk);
                #2;
                exc = '0;
            end
            "h": begin
                hw_int = r.data[hw_int_w-1:0];
                @(posedge clk);
                #2;
            end
            "i", "p", "a": begin
                @(negedge clk);
                if (r.op == "i") begin
                    check_bit("irq_pending", irq_pending, r.expected[1]);
                    check_bit("idle_wake", idle_wake, r.expected[0]);
                end else if (r.op == "p") begin
                    check_plv("plv", plv, r.expected[plv_w-1:0]);
                end else begin
                    check_word("era", era, r.expected);
                end
                @(posedge clk);
                #2;
            end
            "t": wait_timer_irq(r.data);
            default: note_failure($sformatf("unknown stimulus operation %c", r.op));
        endcase
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin : main
        rstn        = 1'b0;
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        adr         = '0;
        dat_w       = '0;
        wmask       = '0;
        exc         = '0;
        hw_int      = '0;
        rng         = 32'd93;
        cur_test    = 0;
        n_tests     = 0;
        n_checks    = 0;
        n_errors    = 0;
        test_errors = 0;
        load_stimulus();
        watchdog_ns = 64'(clk_period) * 20 * recs.size() + 2000;
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(posedge clk);
        #2;
        if (recs.size() == 0) begin
            note_failure("no stimulus records were read");
        end else begin
            foreach (recs[i]) begin
                run_record(recs[i]);
            end
            close_test();
        end
        $display("tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0 && n_checks > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, run stopped", watchdog_ns);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: testbench/csr_stim.txt
# op test addr mask data expected, all hex except test
# ops: w write, x random write, m model read, r read, k write with capture, e event, h hw_int, i irq/idle, p plv, a era, t timer wait
x 1 030 0 0 0
x 1 031 0 0 0
x 1 032 0 0 0
x 1 033 0 0 0
x 1 006 0 0 0
x 1 00c 0 0 0
x 1 030 0 0 0
m 1 030 0 0 0
m 1 031 0 0 0
m 1 032 0 0 0
m 1 033 0 0 0
m 1 006 0 0 0
m 1 00c 0 0 0
r 1 00c 3f 0 0
r 1 7ff ffffffff 0 0
r 1 020 ffffffff 0 0
w 2 000 7 7 0
p 2 0 0 0 3
e 2 1 0 0 0
p 2 0 0 0 0
r 2 000 7 0 0
r 2 001 7 0 7
e 2 2 0 0 0
p 2 0 0 0 3
r 2 000 7 0 7
e 3 4 47 0 0
r 3 005 7fff0000 0 00470000
e 3 4 40 0 0
r 3 005 7fff0000 0 0
e 3 4 0d 0 0
r 3 005 7fff0000 0 000d0000
e 3 8 0 1c000100 0
a 3 0 0 0 1c000100
r 3 006 ffffffff 0 1c000100
k 3 006 ffffffff deadbeef 1c000200
r 3 006 ffffffff 0 1c000200
a 3 0 0 0 1c000200
k 3 005 3 3 4b
r 3 005 7fff0003 0 004b0000
w 4 004 1fff 4 0
w 4 000 7 4 0
h 4 0 0 01 0
i 4 0 0 0 3
r 4 005 3fc 0 004
h 4 0 0 10 0
i 4 0 0 0 1
r 4 005 3fc 0 040
h 4 0 0 0 0
i 4 0 0 0 0
w 4 000 7 0 0
h 4 0 0 01 0
i 4 0 0 0 1
h 4 0 0 0 0
w 5 004 1fff 800 0
w 5 000 7 4 0
w 5 041 ffffffff 15 0
t 5 0 0 5 0
r 5 005 800 0 800
w 5 044 1 1 0
r 5 005 800 0 0
i 5 0 0 0 0
r 5 041 ffffffff 0 15
r 5 044 ffffffff 0 0

// File: list.f
+incdir+testbench
verilog/csr_pkg.sv
verilog/csr_wb_port.sv
verilog/csr_exc_regs.sv
verilog/csr_timer.sv
verilog/csr_top.sv
testbench/tb_csr.sv

// File: Makefile
# Verilator simulation of the CSR block

VERILATOR ?= verilator
TOP       ?= tb_csr
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

.PHONY: sim clean
